/* logic/color_defines.svh */
// shared constants for the RGBW color generator; include wherever a mode code or width is needed
`ifndef COLOR_DEFINES_SVH
`define COLOR_DEFINES_SVH

// host mode codes
`define COLOR_MODE_PASS 8'h21
`define COLOR_MODE_GEN 8'hA4

// width of one intensity channel
`define COLOR_CH_W 8

// hue ramp shape
// one channel moves by this much per step
`define COLOR_RAMP_STEP 7
// steps in one hue segment
`define COLOR_SEG_LEN 42
// ramp stays in the last segment once it gets there
`define COLOR_SEG_LAST 5

// full 8x8 product
`define COLOR_PROD_W 16

`endif

/* logic/color_pkg.sv */
// struct types shared by the color generator blocks and the testbench, used by scoped name
`include "color_defines.svh"

package color_pkg;

    // one intensity channel
    typedef logic [`COLOR_CH_W-1:0] channel_t;

    // ramp and white mix result, no white channel
    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    // full output color, also the direct passthrough value
    typedef struct packed {
        channel_t w;
        channel_t r;
        channel_t g;
        channel_t b;
    } rgbw_t;

    // host frame request, held stable while req is high and ack low
    typedef struct packed {
        logic [7:0] mode;
        channel_t   hue_idx;
        channel_t   white;
        channel_t   intensity;
        rgbw_t      direct;
    } frame_t;

    // multiplier operands, a is the gain
    typedef struct packed {
        channel_t a;
        channel_t b;
    } mult_op_t;

endpackage

/* logic/chroma_gen.sv */
// walks the six-segment hue ramp one step per cycle, then mixes in white with saturation
`include "color_defines.svh"

module chroma_gen
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  color_pkg::channel_t hue_idx,
    input  color_pkg::channel_t white,
    output logic                done,
    output color_pkg::rgb_t     mixed
);

    localparam color_pkg::channel_t STEP = `COLOR_RAMP_STEP;
    localparam logic [2:0] SEG_LAST = `COLOR_SEG_LAST;
    localparam logic [5:0] SEG_END = `COLOR_SEG_LEN - 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RAMP,
        ST_MIX
    } state_t;

    state_t              state;
    // steps still to walk
    color_pkg::channel_t steps_left;
    color_pkg::channel_t white_q;
    // current segment and position inside it
    logic [2:0]          seg;
    logic [5:0]          seg_pos;
    color_pkg::rgb_t     ramp;

    // add with clamp at full scale
    function automatic color_pkg::channel_t sat_add(input color_pkg::channel_t x,
                                                    input color_pkg::channel_t y);
        logic [`COLOR_CH_W:0] sum;
        sum = {1'b0, x} + {1'b0, y};
        return sum[`COLOR_CH_W] ? '1 : sum[`COLOR_CH_W-1:0];
    endfunction

    // one step down, clamp at zero
    function automatic color_pkg::channel_t step_down(input color_pkg::channel_t x);
        return (x < STEP) ? '0 : x - STEP;
    endfunction

    // sequencing
    // h steps, one idle check, one mix cycle: done lands h+2 after start
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (start)
                        state <= ST_RAMP;
                end
                ST_RAMP:
                begin
                    if (steps_left == '0)
                        state <= ST_MIX;
                end
                default:
                begin
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ramp walk and white mix
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && start)
        begin
            // walk starts from black
            ramp       <= '0;
            steps_left <= hue_idx;
            white_q    <= white;
            seg        <= '0;
            seg_pos    <= '0;
        end
        else if (state == ST_RAMP && steps_left != '0)
        begin
            steps_left <= steps_left - 1'b1;
            // two channels pinned, third one moves
            case (seg)
                3'd0:
                begin
                    ramp.r <= '1;
                    ramp.g <= '0;
                    ramp.b <= sat_add(ramp.b, STEP);
                end
                3'd1:
                begin
                    ramp.b <= '1;
                    ramp.g <= '0;
                    ramp.r <= step_down(ramp.r);
                end
                3'd2:
                begin
                    ramp.b <= '1;
                    ramp.r <= '0;
                    ramp.g <= sat_add(ramp.g, STEP);
                end
                3'd3:
                begin
                    ramp.g <= '1;
                    ramp.r <= '0;
                    ramp.b <= step_down(ramp.b);
                end
                3'd4:
                begin
                    ramp.g <= '1;
                    ramp.b <= '0;
                    ramp.r <= sat_add(ramp.r, STEP);
                end
                default:
                begin
                    ramp.r <= '1;
                    ramp.b <= '0;
                    ramp.g <= step_down(ramp.g);
                end
            endcase
            // next segment after 42 steps, last one runs on
            if (seg_pos == SEG_END && seg != SEG_LAST)
            begin
                seg     <= seg + 1'b1;
                seg_pos <= '0;
            end
            else
            begin
                seg_pos <= seg_pos + 1'b1;
            end
        end
        else if (state == ST_MIX)
        begin
            mixed.r <= sat_add(ramp.r, white_q);
            mixed.g <= sat_add(ramp.g, white_q);
            mixed.b <= sat_add(ramp.b, white_q);
        end
    end

    // controller only starts a walk once the previous one is finished
    assert property (@(posedge clk) disable iff (!reset) start |-> state == ST_IDLE);

endmodule

/* logic/shift_add_mult.sv */
// unsigned 8x8 shift-add multiplier, one bit per cycle, behind a four-phase ld/ok handshake
`include "color_defines.svh"

module shift_add_mult
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ld,
    input  color_pkg::mult_op_t      op,
    output logic                     ok,
    output logic [`COLOR_PROD_W-1:0] prod
);

    logic                     busy;
    logic [2:0]               bit_cnt;
    // shifted copy of operand b
    logic [`COLOR_PROD_W-1:0] mcand;
    // operand a, lsb picks the add
    color_pkg::channel_t      mplier;
    logic [`COLOR_PROD_W-1:0] partial;

    // accumulate this cycle's partial product
    assign partial = mplier[0] ? prod + mcand : prod;

    // handshake and bit count
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            busy    <= 1'b0;
            ok      <= 1'b0;
            bit_cnt <= '0;
        end
        else if (ok)
        begin
            // hold result until the requester lets go
            if (!ld)
                ok <= 1'b0;
        end
        else if (busy)
        begin
            bit_cnt <= bit_cnt + 1'b1;
            // eighth add, result ready
            if (bit_cnt == 3'd7)
            begin
                busy <= 1'b0;
                ok   <= 1'b1;
            end
        end
        else if (ld)
        begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end
    end

    // shift-add datapath
    always_ff @(posedge clk)
    begin
        if (!busy && !ok && ld)
        begin
            prod   <= '0;
            mcand  <= {{(`COLOR_PROD_W - `COLOR_CH_W){1'b0}}, op.b};
            mplier <= op.a;
        end
        else if (busy)
        begin
            prod   <= partial;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // requester keeps ld up for the whole multiply
    assert property (@(posedge clk) disable iff (!reset) $rose(ok) |-> ld);

endmodule

/* logic/intensity_scaler.sv */
// scales white, red, green and blue by intensity through the shared multiplier, keeps high bytes
`include "color_defines.svh"

module intensity_scaler
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  color_pkg::channel_t      intensity,
    input  color_pkg::channel_t      white,
    input  color_pkg::rgb_t          mixed,
    output logic                     done,
    output color_pkg::rgbw_t         scaled,
    output logic                     ld,
    output color_pkg::mult_op_t      op,
    input  logic                     ok,
    input  logic [`COLOR_PROD_W-1:0] prod
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_WAIT
    } state_t;

    state_t              state;
    // 0 white, 1 red, 2 green, 3 blue
    logic [1:0]          ch_idx;
    color_pkg::channel_t gain;
    color_pkg::rgbw_t    src;

    // operand select, steady while a channel is in flight
    always_comb
    begin
        op.a = gain;
        case (ch_idx)
            2'd0:    op.b = src.w;
            2'd1:    op.b = src.r;
            2'd2:    op.b = src.g;
            default: op.b = src.b;
        endcase
    end

    // four multiplier transactions in a row
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state  <= ST_IDLE;
            ld     <= 1'b0;
            done   <= 1'b0;
            ch_idx <= '0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        ch_idx <= '0;
                        state  <= ST_LOAD;
                    end
                end
                ST_LOAD:
                begin
                    // wait for ok from the last product to clear
                    if (!ok)
                    begin
                        ld    <= 1'b1;
                        state <= ST_WAIT;
                    end
                end
                default:
                begin
                    if (ok)
                    begin
                        ld <= 1'b0;
                        if (ch_idx == 2'd3)
                        begin
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end
                        else
                        begin
                            ch_idx <= ch_idx + 1'b1;
                            state  <= ST_LOAD;
                        end
                    end
                end
            endcase
        end
    end

    // operand capture and product high bytes
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && start)
        begin
            gain <= intensity;
            // white on top, then the mixed color
            src  <= {white, mixed};
        end
        if (state == ST_WAIT && ok)
        begin
            case (ch_idx)
                2'd0:    scaled.w <= prod[`COLOR_PROD_W-1 -: `COLOR_CH_W];
                2'd1:    scaled.r <= prod[`COLOR_PROD_W-1 -: `COLOR_CH_W];
                2'd2:    scaled.g <= prod[`COLOR_PROD_W-1 -: `COLOR_CH_W];
                default: scaled.b <= prod[`COLOR_PROD_W-1 -: `COLOR_CH_W];
            endcase
        end
    end

    // multiplier reads op across the whole ld phase
    assert property (@(posedge clk) disable iff (!reset) ld && $past(ld) |-> $stable(op));

endmodule

/* logic/color_ctrl.sv */
// host frame handshake and mode decode, drives the color output register and ack
`include "color_defines.svh"

module color_ctrl
(
    input  logic              clk,
    input  logic              reset,
    input  color_pkg::frame_t frame,
    input  logic              req,
    output color_pkg::rgbw_t  color,
    output logic              ack,
    output logic              chroma_start,
    input  logic              chroma_done,
    input  color_pkg::rgb_t   mixed,
    output logic              scale_start,
    input  logic              scale_done,
    input  color_pkg::rgbw_t  scaled
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHROMA,
        ST_SCALE,
        ST_HOLD
    } state_t;

    state_t            state;
    // last req, for the rising edge
    logic              req_q;
    color_pkg::frame_t frame_q;

    // frame capture on req rising
    always_ff @(posedge clk)
    begin
        if (req && !req_q)
            frame_q <= frame;
    end

    // frame sequencing
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state        <= ST_IDLE;
            req_q        <= 1'b0;
            ack          <= 1'b0;
            chroma_start <= 1'b0;
            scale_start  <= 1'b0;
            color        <= '0;
        end
        else
        begin
            req_q        <= req;
            chroma_start <= 1'b0;
            scale_start  <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    // frame_q was loaded on the previous edge
                    if (req_q)
                    begin
                        if (frame_q.mode == `COLOR_MODE_GEN)
                        begin
                            chroma_start <= 1'b1;
                            state        <= ST_CHROMA;
                        end
                        else
                        begin
                            // unknown codes just complete
                            if (frame_q.mode == `COLOR_MODE_PASS)
                                color <= frame_q.direct;
                            ack   <= 1'b1;
                            state <= ST_HOLD;
                        end
                    end
                end
                ST_CHROMA:
                begin
                    // mixed holds until the next chroma start
                    if (chroma_done)
                    begin
                        scale_start <= 1'b1;
                        state       <= ST_SCALE;
                    end
                end
                ST_SCALE:
                begin
                    if (scale_done)
                    begin
                        color <= scaled;
                        ack   <= 1'b1;
                        state <= ST_HOLD;
                    end
                end
                default:
                begin
                    // back-pressure, no new frame until req drops
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // ack only answers a live request, req high on the edge that raised ack
    assert property (@(posedge clk) disable iff (!reset) $rose(ack) |-> $past(req));

endmodule

/* logic/color_gen_top.sv */
// top level of the RGBW color generator, connects controller, ramp, scaler and multiplier
`include "color_defines.svh"

module color_gen_top
(
    input  logic              clk,
    input  logic              reset,
    input  color_pkg::frame_t frame,
    input  logic              req,
    output color_pkg::rgbw_t  color,
    output logic              ack
);

    logic                     chroma_start;
    logic                     chroma_done;
    logic                     scale_start;
    logic                     scale_done;
    color_pkg::rgb_t          mixed;
    color_pkg::rgbw_t         scaled;
    // multiplier handshake
    logic                     mult_ld;
    logic                     mult_ok;
    color_pkg::mult_op_t      mult_op;
    logic [`COLOR_PROD_W-1:0] mult_prod;

    color_ctrl i_ctrl
    (
        .clk          (clk),
        .reset        (reset),
        .frame        (frame),
        .req          (req),
        .color        (color),
        .ack          (ack),
        .chroma_start (chroma_start),
        .chroma_done  (chroma_done),
        .mixed        (mixed),
        .scale_start  (scale_start),
        .scale_done   (scale_done),
        .scaled       (scaled)
    );

    // host holds frame until ack, so the fields feed the datapath directly
    chroma_gen i_chroma
    (
        .clk     (clk),
        .reset   (reset),
        .start   (chroma_start),
        .hue_idx (frame.hue_idx),
        .white   (frame.white),
        .done    (chroma_done),
        .mixed   (mixed)
    );

    intensity_scaler i_scaler
    (
        .clk       (clk),
        .reset     (reset),
        .start     (scale_start),
        .intensity (frame.intensity),
        .white     (frame.white),
        .mixed     (mixed),
        .done      (scale_done),
        .scaled    (scaled),
        .ld        (mult_ld),
        .op        (mult_op),
        .ok        (mult_ok),
        .prod      (mult_prod)
    );

    shift_add_mult i_mult
    (
        .clk   (clk),
        .reset (reset),
        .ld    (mult_ld),
        .op    (mult_op),
        .ok    (mult_ok),
        .prod  (mult_prod)
    );

endmodule

/* sim/color_model.svh */
// reference model of the color generator, included inside the testbench module for expected values
`ifndef COLOR_MODEL_SVH
`define COLOR_MODEL_SVH

// channel add, clamped at full scale
function automatic color_pkg::channel_t clamp_add(input color_pkg::channel_t x,
                                                  input color_pkg::channel_t y);
    int sum;
    sum = int'(x) + int'(y);
    if (sum > 255)
        sum = 255;
    return sum[7:0];
endfunction

// one ramp step up, saturating
function automatic color_pkg::channel_t ramp_up(input color_pkg::channel_t x);
    int v;
    v = int'(x) + `COLOR_RAMP_STEP;
    if (v > 255)
        v = 255;
    return v[7:0];
endfunction

// one ramp step down, floor at zero
function automatic color_pkg::channel_t ramp_down(input color_pkg::channel_t x);
    int v;
    v = int'(x) - `COLOR_RAMP_STEP;
    if (v < 0)
        v = 0;
    return v[7:0];
endfunction

// walk of hue steps from black, segment is step / 42 capped at the last one
function automatic color_pkg::rgb_t hue_ramp(input color_pkg::channel_t hue);
    color_pkg::rgb_t c;
    int s;
    int seg;
    c = '0;
    for (s = 0; s < int'(hue); s++)
    begin
        seg = s / `COLOR_SEG_LEN;
        if (seg > `COLOR_SEG_LAST)
            seg = `COLOR_SEG_LAST;
        case (seg)
            0:
            begin
                c.r = 8'hff;
                c.g = 8'h00;
                c.b = ramp_up(c.b);
            end
            1:
            begin
                c.b = 8'hff;
                c.g = 8'h00;
                c.r = ramp_down(c.r);
            end
            2:
            begin
                c.b = 8'hff;
                c.r = 8'h00;
                c.g = ramp_up(c.g);
            end
            3:
            begin
                c.g = 8'hff;
                c.r = 8'h00;
                c.b = ramp_down(c.b);
            end
            4:
            begin
                c.g = 8'hff;
                c.b = 8'h00;
                c.r = ramp_up(c.r);
            end
            default:
            begin
                c.r = 8'hff;
                c.b = 8'h00;
                c.g = ramp_down(c.g);
            end
        endcase
    end
    return c;
endfunction

// white added to each color channel
function automatic color_pkg::rgb_t white_mix(input color_pkg::rgb_t c,
                                              input color_pkg::channel_t white);
    color_pkg::rgb_t m;
    m.r = clamp_add(c.r, white);
    m.g = clamp_add(c.g, white);
    m.b = clamp_add(c.b, white);
    return m;
endfunction

// (gain * channel) >> 8
function automatic color_pkg::channel_t scale_channel(input color_pkg::channel_t gain,
                                                      input color_pkg::channel_t ch);
    int p;
    p = int'(gain) * int'(ch);
    return p[15:8];
endfunction

// full generate-mode result for one frame
function automatic color_pkg::rgbw_t expected_gen(input color_pkg::frame_t f);
    color_pkg::rgb_t  m;
    color_pkg::rgbw_t o;
    m = white_mix(hue_ramp(f.hue_idx), f.white);
    o.w = scale_channel(f.intensity, f.white);
    o.r = scale_channel(f.intensity, m.r);
    o.g = scale_channel(f.intensity, m.g);
    o.b = scale_channel(f.intensity, m.b);
    return o;
endfunction

`endif

/* sim/tb_color_gen.sv */
// self-checking testbench for the color generator, random and corner frames against a model
`include "color_defines.svh"

module tb_color_gen;

    localparam int RANDOM_GEN_FRAMES = 200;
    // longest generate frame is well under this
    localparam int ACK_TIMEOUT = 1000;
    localparam int DROP_TIMEOUT = 4;

    logic              clk;
    logic              reset;
    color_pkg::frame_t frame;
    logic              req;
    color_pkg::rgbw_t  color;
    logic              ack;

    logic [31:0]       lcg_state;
    int                mismatch_count;
    int                timeout_count;
    int                frame_count;
    int                gen_frames;
    // set on a timeout, remaining frames are skipped
    bit                aborted;
    // color the DUT should be holding
    color_pkg::rgbw_t  exp_color;

    `include "color_model.svh"

    color_gen_top i_dut
    (
        .clk   (clk),
        .reset (reset),
        .frame (frame),
        .req   (req),
        .color (color),
        .ack   (ack)
    );

    always #2 clk = ~clk;

    // lcg, numerical recipes constants
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper byte, low lcg bits are weak
    function automatic color_pkg::channel_t rand_byte();
        logic [31:0] r;
        r = next_rand();
        return r[31:24];
    endfunction

    task automatic check_color(input string name, input color_pkg::rgbw_t got,
                               input color_pkg::rgbw_t exp);
        if (got.w !== exp.w)
        begin
            $display("MISMATCH %s.w got %h expected %h at %0t", name, got.w, exp.w, $time);
            mismatch_count++;
        end
        if (got.r !== exp.r)
        begin
            $display("MISMATCH %s.r got %h expected %h at %0t", name, got.r, exp.r, $time);
            mismatch_count++;
        end
        if (got.g !== exp.g)
        begin
            $display("MISMATCH %s.g got %h expected %h at %0t", name, got.g, exp.g, $time);
            mismatch_count++;
        end
        if (got.b !== exp.b)
        begin
            $display("MISMATCH %s.b got %h expected %h at %0t", name, got.b, exp.b, $time);
            mismatch_count++;
        end
    endtask

    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH ack got %h expected %h at %0t", got, exp, $time);
            mismatch_count++;
        end
    endtask

    // wait for ack to reach level, color must hold meanwhile
    task automatic wait_ack(input logic level, input int limit, input color_pkg::rgbw_t hold);
        int cycles;
        bit done;
        cycles = 0;
        done   = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            if (ack === level)
            begin
                done = 1'b1;
            end
            else
            begin
                check_color("color", color, hold);
                cycles++;
                if (cycles >= limit)
                begin
                    $display("timeout: ack did not go to %0d within %0d cycles in frame %0d",
                             level, limit, frame_count);
                    timeout_count++;
                    aborted = 1'b1;
                    done    = 1'b1;
                end
            end
        end
    endtask

    // one full four-phase frame with random req hold and idle gap
    task automatic run_frame(input color_pkg::frame_t f);
        color_pkg::rgbw_t next_color;
        int hold_cycles;
        int gap;
        if (aborted)
            return;
        frame_count++;
        // unknown codes keep the old color
        if (f.mode == `COLOR_MODE_GEN)
            next_color = expected_gen(f);
        else if (f.mode == `COLOR_MODE_PASS)
            next_color = f.direct;
        else
            next_color = exp_color;
        hold_cycles = rand_byte() % 6;
        gap = rand_byte() % 3;
        @(negedge clk);
        frame = f;
        req   = 1'b1;
        wait_ack(1'b1, ACK_TIMEOUT, exp_color);
        if (aborted)
            return;
        check_color("color", color, next_color);
        exp_color = next_color;
        // back-pressure, ack stays up with req
        repeat (hold_cycles)
        begin
            @(negedge clk);
            check_ack(ack, 1'b1);
            check_color("color", color, exp_color);
        end
        req = 1'b0;
        wait_ack(1'b0, DROP_TIMEOUT, exp_color);
        if (aborted)
            return;
        check_color("color", color, exp_color);
        // frame is don't care while idle
        repeat (gap)
        begin
            frame = {next_rand(), next_rand()};
            @(negedge clk);
            check_ack(ack, 1'b0);
            check_color("color", color, exp_color);
        end
    endtask

    function automatic color_pkg::frame_t random_frame();
        color_pkg::frame_t f;
        int pick;
        pick = rand_byte() % 10;
        if (pick < 4)
        begin
            f.mode = `COLOR_MODE_GEN;
        end
        else if (pick < 8)
        begin
            f.mode = `COLOR_MODE_PASS;
        end
        else
        begin
            f.mode = rand_byte();
            // nudge off the two real codes
            if (f.mode == `COLOR_MODE_GEN || f.mode == `COLOR_MODE_PASS)
                f.mode = f.mode ^ 8'h01;
        end
        f.hue_idx   = rand_byte();
        f.white     = rand_byte();
        f.intensity = rand_byte();
        f.direct.w  = rand_byte();
        f.direct.r  = rand_byte();
        f.direct.g  = rand_byte();
        f.direct.b  = rand_byte();
        return f;
    endfunction

    // passthrough, unknown code, then segment edges with saturating white and gain
    task automatic run_corners();
        color_pkg::frame_t   f;
        color_pkg::channel_t hues [5];
        int i;
        hues[0] = 8'd0;
        hues[1] = 8'd41;
        hues[2] = 8'd42;
        hues[3] = 8'd251;
        hues[4] = 8'd255;
        f = random_frame();
        f.mode = `COLOR_MODE_PASS;
        run_frame(f);
        f = random_frame();
        f.mode = 8'h5a;
        run_frame(f);
        for (i = 0; i < 5; i++)
        begin
            f = random_frame();
            f.mode      = `COLOR_MODE_GEN;
            f.hue_idx   = hues[i];
            f.white     = 8'hff;
            f.intensity = 8'hff;
            run_frame(f);
            f.white     = rand_byte();
            f.intensity = 8'h00;
            run_frame(f);
            f.white     = 8'h00;
            f.intensity = 8'hff;
            run_frame(f);
        end
    endtask

    initial
    begin
        color_pkg::frame_t f;
        clk            = 1'b0;
        reset          = 1'b0;
        req            = 1'b0;
        frame          = '0;
        lcg_state      = 32'hfd90_1307;
        mismatch_count = 0;
        timeout_count  = 0;
        frame_count    = 0;
        gen_frames     = 0;
        aborted        = 1'b0;
        exp_color      = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        // idle state out of reset
        check_ack(ack, 1'b0);
        check_color("color", color, '0);
        run_corners();
        while (gen_frames < RANDOM_GEN_FRAMES && !aborted)
        begin
            f = random_frame();
            if (f.mode == `COLOR_MODE_GEN)
                gen_frames++;
            run_frame(f);
        end
        $display("summary: %0d frames, %0d mismatches, %0d timeouts",
                 frame_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
+incdir+sim
logic/color_pkg.sv
logic/chroma_gen.sv
logic/shift_add_mult.sv
logic/intensity_scaler.sv
logic/color_ctrl.sv
logic/color_gen_top.sv
sim/tb_color_gen.sv

/* run_sim.sh */
#!/bin/sh
# build the color generator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_color_gen \
    -Mdir obj_dir -o tb_color_gen
output=$(./obj_dir/tb_color_gen)
echo "$output"
if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
